//--- hdl/issue_pkg.sv
package issue_pkg;

    // ----------------------------------------
    // widths and sizes
    // ----------------------------------------
    localparam int unsigned XLEN            = 32;
    localparam int unsigned REG_ADDR_W      = 5;
    localparam int unsigned NR_REGS         = 32;
    localparam int unsigned TRANS_ID_W      = 3;
    localparam int unsigned NR_COMMIT_PORTS = 2;

    // functional unit classes, NONE marks a free register in the clobber list
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        MULT,
        LOAD,
        STORE,
        CSR
    } fu_e;

    // operations, only SFENCE_VMA is looked at in this stage
    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, MUL,
        LW, SW, BEQ, JAL, CSRRW, SFENCE_VMA
    } fu_op_e;

    // ----------------------------------------
    // scoreboard entry offered for issue
    // ----------------------------------------
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [TRANS_ID_W-1:0] trans_id;
        fu_e                   fu;
        fu_op_e                op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        // immediate
        logic [XLEN-1:0]       result;
        logic                  use_imm;
        logic                  use_pc;
        logic                  use_zimm;
        logic                  ex_valid;
    } issue_entry_t;

    // pending producer per integer register
    typedef fu_e [NR_REGS-1:0] clobber_t;

    // one commit write port
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } commit_t;

    typedef commit_t [NR_COMMIT_PORTS-1:0] commit_vec_t;

    // ----------------------------------------
    // towards execute
    // ----------------------------------------
    typedef struct packed {
        fu_e                   fu;
        fu_op_e                op;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;
        logic [XLEN-1:0]       imm;
        logic [TRANS_ID_W-1:0] trans_id;
    } fu_data_t;

    typedef struct packed {
        logic alu;
        logic branch;
        logic mult;
        logic lsu;
        logic csr;
    } fu_valid_t;

    // flu covers alu, branch, csr and mult
    typedef struct packed {
        logic flu;
        logic lsu;
    } fu_ready_t;

endpackage

//--- hdl/int_regfile.sv
module int_regfile (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    // read ports, rs1 and rs2
    input  logic [issue_pkg::REG_ADDR_W-1:0]    raddr_a_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0]    raddr_b_i,
    output logic [issue_pkg::XLEN-1:0]          rdata_a_o,
    output logic [issue_pkg::XLEN-1:0]          rdata_b_o,
    // write ports from commit
    input  issue_pkg::commit_vec_t              commit_i
);

    // x0 has no storage
    logic [issue_pkg::XLEN-1:0] regs_q [issue_pkg::NR_REGS-1:1];

    // ----------------------------------------
    // write side
    // ----------------------------------------
    // ports are walked in ascending order so the highest port wins
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned r = 1; r < issue_pkg::NR_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // ----------------------------------------
    // read side, combinational
    // ----------------------------------------
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

    // two commits to one register must agree, or the older value would be lost silently
    for (genvar i = 0; i < issue_pkg::NR_COMMIT_PORTS; i++) begin : gen_port_a
        for (genvar j = i + 1; j < issue_pkg::NR_COMMIT_PORTS; j++) begin : gen_port_b
            a_same_addr_same_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
                (commit_i[i].we && commit_i[j].we && (commit_i[i].waddr != '0)
                 && (commit_i[i].waddr == commit_i[j].waddr))
                |-> (commit_i[i].wdata == commit_i[j].wdata));
        end
    end

endmodule

//--- hdl/operand_hazard.sv
module operand_hazard (
    input  issue_pkg::issue_entry_t issue_instr_i,
    // clobber list from the scoreboard
    input  issue_pkg::clobber_t     clobber_i,
    // scoreboard has the source value ready
    input  logic                    rs1_valid_i,
    input  logic                    rs2_valid_i,
    // take rs1_i / rs2_i instead of the register file
    output logic                    fwd_rs1_o,
    output logic                    fwd_rs2_o,
    output logic                    stall_o
);

    issue_pkg::fu_e producer_rs1;
    issue_pkg::fu_e producer_rs2;
    logic           check_rs1;
    logic           busy_rs1;
    logic           busy_rs2;
    logic           sfence;
    logic           can_fwd_rs1;
    logic           can_fwd_rs2;
    logic           stall_rs1;
    logic           stall_rs2;

    // ----------------------------------------
    // clobber lookup
    // ----------------------------------------
    assign producer_rs1 = clobber_i[issue_instr_i.rs1];
    assign producer_rs2 = clobber_i[issue_instr_i.rs2];

    // zimm sits in the rs1 field, nothing to wait for then
    assign check_rs1 = !issue_instr_i.use_zimm;

    assign busy_rs1 = check_rs1 && (producer_rs1 != issue_pkg::NONE);
    assign busy_rs2 = (producer_rs2 != issue_pkg::NONE);

    // ----------------------------------------
    // forward or stall
    // ----------------------------------------
    // csr results only reach us through the register file
    // sfence.vma takes the operand anyway, it does not depend on csr side effects
    assign sfence = (issue_instr_i.op == issue_pkg::SFENCE_VMA);

    assign can_fwd_rs1 = (rs1_valid_i && (producer_rs1 != issue_pkg::CSR)) || sfence;
    assign can_fwd_rs2 = (rs2_valid_i && (producer_rs2 != issue_pkg::CSR)) || sfence;

    assign fwd_rs1_o = busy_rs1 && can_fwd_rs1;
    assign stall_rs1 = busy_rs1 && !can_fwd_rs1;

    assign fwd_rs2_o = busy_rs2 && can_fwd_rs2;
    assign stall_rs2 = busy_rs2 && !can_fwd_rs2;

    // either source missing holds the instruction
    assign stall_o = stall_rs1 || stall_rs2;

    // forwarding a value we are also waiting for would dispatch a stale operand
    a_fwd_xor_stall_rs1: assert final (!(fwd_rs1_o && stall_rs1));

endmodule

//--- hdl/issue_gate.sv
module issue_gate (
    input  issue_pkg::issue_entry_t issue_instr_i,
    input  logic                    issue_valid_i,
    input  issue_pkg::clobber_t     clobber_i,
    input  issue_pkg::commit_vec_t  commit_i,
    input  issue_pkg::fu_ready_t    fu_ready_i,
    // operand not available yet
    input  logic                    stall_i,
    // a multiply sits in ID/EX
    input  logic                    mult_pending_i,
    output logic                    issue_ready_o,
    // transfer that starts a unit
    output logic                    dispatch_o
);

    logic fu_busy;
    logic rd_free;
    logic rd_committing;

    // ----------------------------------------
    // unit busy
    // ----------------------------------------
    always_comb begin
        case (issue_instr_i.fu)
            issue_pkg::ALU, issue_pkg::CTRL_FLOW, issue_pkg::CSR, issue_pkg::MULT:
                fu_busy = !fu_ready_i.flu;
            issue_pkg::LOAD, issue_pkg::STORE:
                fu_busy = !fu_ready_i.lsu;
            default:
                fu_busy = 1'b0;
        endcase
    end

    // ----------------------------------------
    // WAW check
    // ----------------------------------------
    assign rd_free = (clobber_i[issue_instr_i.rd] == issue_pkg::NONE);

    // the pending writer of rd retires this cycle, so rd is free after the edge
    always_comb begin
        rd_committing = 1'b0;
        for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
                rd_committing = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // issue acknowledge
    // ----------------------------------------
    always_comb begin
        issue_ready_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall_i && !fu_busy && (rd_free || rd_committing)) begin
                issue_ready_o = 1'b1;
            end
            // exceptions and fu NONE need no unit and no operands
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == issue_pkg::NONE)) begin
                issue_ready_o = 1'b1;
            end
        end
        // only a multiply may follow a multiply, the flu result bus is shared
        if (mult_pending_i && (issue_instr_i.fu != issue_pkg::MULT)) begin
            issue_ready_o = 1'b0;
        end
    end

    // exceptions are acknowledged but start nothing
    assign dispatch_o = issue_ready_o && !issue_instr_i.ex_valid;

    a_dispatch_needs_valid: assert final (!dispatch_o || issue_valid_i);

endmodule

//--- hdl/issue_ex_regs.sv
module issue_ex_regs (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    input  issue_pkg::issue_entry_t     issue_instr_i,
    // transfer without exception
    input  logic                        dispatch_i,
    // forward selects from the hazard check
    input  logic                        fwd_rs1_i,
    input  logic                        fwd_rs2_i,
    // scoreboard values
    input  logic [issue_pkg::XLEN-1:0]  rs1_i,
    input  logic [issue_pkg::XLEN-1:0]  rs2_i,
    // register file values
    input  logic [issue_pkg::XLEN-1:0]  rdata_a_i,
    input  logic [issue_pkg::XLEN-1:0]  rdata_b_i,
    output issue_pkg::fu_data_t         fu_data_o,
    output issue_pkg::fu_valid_t        fu_valid_o,
    output logic                        mult_pending_o
);

    logic [issue_pkg::XLEN-1:0] operand_a;
    logic [issue_pkg::XLEN-1:0] operand_b;
    issue_pkg::fu_data_t        fu_data_d;
    issue_pkg::fu_data_t        fu_data_q;
    issue_pkg::fu_valid_t       fu_valid_d;
    issue_pkg::fu_valid_t       fu_valid_q;

    // ----------------------------------------
    // operand a
    // ----------------------------------------
    // later choices override earlier ones
    always_comb begin
        operand_a = rdata_a_i;
        if (fwd_rs1_i) begin
            operand_a = rs1_i;
        end
        if (issue_instr_i.use_pc) begin
            operand_a = issue_instr_i.pc;
        end
        // zimm, zero extended from the rs1 field
        if (issue_instr_i.use_zimm) begin
            operand_a = {{(issue_pkg::XLEN - issue_pkg::REG_ADDR_W){1'b0}}, issue_instr_i.rs1};
        end
    end

    // ----------------------------------------
    // operand b
    // ----------------------------------------
    always_comb begin
        operand_b = fwd_rs2_i ? rs2_i : rdata_b_i;
        // store data and branch compare need rs2, their immediate goes through imm
        if (issue_instr_i.use_imm
            && (issue_instr_i.fu != issue_pkg::STORE)
            && (issue_instr_i.fu != issue_pkg::CTRL_FLOW)) begin
            operand_b = issue_instr_i.result;
        end
    end

    always_comb begin
        fu_data_d.fu        = issue_instr_i.fu;
        fu_data_d.op        = issue_instr_i.op;
        fu_data_d.operand_a = operand_a;
        fu_data_d.operand_b = operand_b;
        fu_data_d.imm       = issue_instr_i.result;
        fu_data_d.trans_id  = issue_instr_i.trans_id;
    end

    // ----------------------------------------
    // unit valids
    // ----------------------------------------
    always_comb begin
        fu_valid_d = '0;
        // flush wins over a dispatch in the same cycle
        if (dispatch_i && !flush_i) begin
            case (issue_instr_i.fu)
                issue_pkg::ALU:                     fu_valid_d.alu    = 1'b1;
                issue_pkg::CTRL_FLOW:               fu_valid_d.branch = 1'b1;
                issue_pkg::MULT:                    fu_valid_d.mult   = 1'b1;
                issue_pkg::LOAD, issue_pkg::STORE:  fu_valid_d.lsu    = 1'b1;
                issue_pkg::CSR:                     fu_valid_d.csr    = 1'b1;
                default:                            fu_valid_d        = '0;
            endcase
        end
    end

    // ----------------------------------------
    // ID/EX register
    // ----------------------------------------
    // payload is captured every cycle, the valids tell execute when to look
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_q  <= '{fu: issue_pkg::NONE, op: issue_pkg::ADD, default: '0};
            fu_valid_q <= '0;
        end else begin
            fu_data_q  <= fu_data_d;
            fu_valid_q <= fu_valid_d;
        end
    end

    assign fu_data_o      = fu_data_q;
    assign fu_valid_o     = fu_valid_q;
    assign mult_pending_o = fu_valid_q.mult;

    // single issue, at most one unit starts per cycle
    a_valid_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(fu_valid_o));

endmodule

//--- hdl/issue_read_operands.sv
module issue_read_operands (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    // issue handshake with the scoreboard
    input  issue_pkg::issue_entry_t     issue_instr_i,
    input  logic                        issue_valid_i,
    output logic                        issue_ready_o,
    // scoreboard lookup of the sources
    output logic [issue_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] rs2_o,
    input  logic [issue_pkg::XLEN-1:0]  rs1_i,
    input  logic                        rs1_valid_i,
    input  logic [issue_pkg::XLEN-1:0]  rs2_i,
    input  logic                        rs2_valid_i,
    input  issue_pkg::clobber_t         clobber_i,
    input  issue_pkg::fu_ready_t        fu_ready_i,
    input  issue_pkg::commit_vec_t      commit_i,
    // towards execute
    output issue_pkg::fu_data_t         fu_data_o,
    output issue_pkg::fu_valid_t        fu_valid_o
);

    logic                       stall;
    logic                       fwd_rs1;
    logic                       fwd_rs2;
    logic                       dispatch;
    logic                       mult_pending;
    logic [issue_pkg::XLEN-1:0] rdata_a;
    logic [issue_pkg::XLEN-1:0] rdata_b;

    // the scoreboard looks the sources up in the same cycle
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    // ----------------------------------------
    // register file
    // ----------------------------------------
    int_regfile i_int_regfile (
        .clk_i     ( clk_i             ),
        .rst_ni    ( rst_ni            ),
        .raddr_a_i ( issue_instr_i.rs1 ),
        .raddr_b_i ( issue_instr_i.rs2 ),
        .rdata_a_o ( rdata_a           ),
        .rdata_b_o ( rdata_b           ),
        .commit_i  ( commit_i          )
    );

    // ----------------------------------------
    // hazards and issue
    // ----------------------------------------
    operand_hazard i_operand_hazard (
        .issue_instr_i ( issue_instr_i ),
        .clobber_i     ( clobber_i     ),
        .rs1_valid_i   ( rs1_valid_i   ),
        .rs2_valid_i   ( rs2_valid_i   ),
        .fwd_rs1_o     ( fwd_rs1       ),
        .fwd_rs2_o     ( fwd_rs2       ),
        .stall_o       ( stall         )
    );

    issue_gate i_issue_gate (
        .issue_instr_i  ( issue_instr_i ),
        .issue_valid_i  ( issue_valid_i ),
        .clobber_i      ( clobber_i     ),
        .commit_i       ( commit_i      ),
        .fu_ready_i     ( fu_ready_i    ),
        .stall_i        ( stall         ),
        .mult_pending_i ( mult_pending  ),
        .issue_ready_o  ( issue_ready_o ),
        .dispatch_o     ( dispatch      )
    );

    // operand select and ID/EX register
    issue_ex_regs i_issue_ex_regs (
        .clk_i          ( clk_i         ),
        .rst_ni         ( rst_ni        ),
        .flush_i        ( flush_i       ),
        .issue_instr_i  ( issue_instr_i ),
        .dispatch_i     ( dispatch      ),
        .fwd_rs1_i      ( fwd_rs1       ),
        .fwd_rs2_i      ( fwd_rs2       ),
        .rs1_i          ( rs1_i         ),
        .rs2_i          ( rs2_i         ),
        .rdata_a_i      ( rdata_a       ),
        .rdata_b_i      ( rdata_b       ),
        .fu_data_o      ( fu_data_o     ),
        .fu_valid_o     ( fu_valid_o    ),
        .mult_pending_o ( mult_pending  )
    );

endmodule

//--- testbench/tb_issue_model.svh
    // ----------------------------------------
    // reference model of the issue stage
    // ----------------------------------------
    typedef enum {SRC_RF, SRC_FWD, SRC_STALL} src_e;

    // shadow of the integer register file
    logic [issue_pkg::XLEN-1:0] model_regs [issue_pkg::NR_REGS];
    // what ID/EX should hold after the next edge
    issue_pkg::fu_data_t        exp_data;
    issue_pkg::fu_valid_t       exp_valid;

    task automatic model_reset();
        for (int unsigned r = 0; r < issue_pkg::NR_REGS; r++) begin
            model_regs[r] = '0;
        end
        exp_data  = '{fu: issue_pkg::NONE, op: issue_pkg::ADD, default: '0};
        exp_valid = '0;
    endtask

    function automatic logic [issue_pkg::XLEN-1:0] reg_value(
        input logic [issue_pkg::REG_ADDR_W-1:0] addr
    );
        // x0 always zero
        if (addr == 0) begin
            return '0;
        end
        return model_regs[addr];
    endfunction

    // free register, forwardable producer, or wait
    function automatic src_e source_status(input issue_pkg::fu_e producer, input logic sb_valid);
        if (producer == issue_pkg::NONE) begin
            return SRC_RF;
        end
        if (issue_instr.op == issue_pkg::SFENCE_VMA) begin
            return SRC_FWD;
        end
        if (sb_valid && (producer != issue_pkg::CSR)) begin
            return SRC_FWD;
        end
        return SRC_STALL;
    endfunction

    // zimm occupies the rs1 field, never waits
    function automatic src_e rs1_status();
        if (issue_instr.use_zimm) begin
            return SRC_RF;
        end
        return source_status(clobber[issue_instr.rs1], rs1_valid);
    endfunction

    function automatic src_e rs2_status();
        return source_status(clobber[issue_instr.rs2], rs2_valid);
    endfunction

    function automatic logic model_ready();
        logic unit_ok;
        logic rd_ok;
        if (issue_instr.fu inside {issue_pkg::LOAD, issue_pkg::STORE}) begin
            unit_ok = fu_ready.lsu;
        end else begin
            unit_ok = fu_ready.flu;
        end
        // WAW, unless the pending writer commits right now
        rd_ok = (clobber[issue_instr.rd] == issue_pkg::NONE);
        for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
            if (commit[p].we && (commit[p].waddr == issue_instr.rd)) begin
                rd_ok = 1'b1;
            end
        end
        if (!issue_valid) begin
            return 1'b0;
        end
        // a multiply in ID/EX lets only another multiply through
        if (exp_valid.mult && (issue_instr.fu != issue_pkg::MULT)) begin
            return 1'b0;
        end
        if (issue_instr.ex_valid || (issue_instr.fu == issue_pkg::NONE)) begin
            return 1'b1;
        end
        return (rs1_status() != SRC_STALL) && (rs2_status() != SRC_STALL) && unit_ok && rd_ok;
    endfunction

    // advance the model by one edge
    task automatic model_step(input logic ready);
        exp_data.fu       = issue_instr.fu;
        exp_data.op       = issue_instr.op;
        exp_data.trans_id = issue_instr.trans_id;
        exp_data.imm      = issue_instr.result;
        exp_data.operand_a = (rs1_status() == SRC_FWD) ? rs1_val : reg_value(issue_instr.rs1);
        if (issue_instr.use_pc) begin
            exp_data.operand_a = issue_instr.pc;
        end
        if (issue_instr.use_zimm) begin
            exp_data.operand_a = '0;
            exp_data.operand_a[issue_pkg::REG_ADDR_W-1:0] = issue_instr.rs1;
        end
        exp_data.operand_b = (rs2_status() == SRC_FWD) ? rs2_val : reg_value(issue_instr.rs2);
        // store and branch keep rs2 in operand b
        if (issue_instr.use_imm
            && !(issue_instr.fu inside {issue_pkg::STORE, issue_pkg::CTRL_FLOW})) begin
            exp_data.operand_b = issue_instr.result;
        end
        exp_valid = '0;
        if (issue_valid && ready && !issue_instr.ex_valid && !flush) begin
            case (issue_instr.fu)
                issue_pkg::ALU:       exp_valid.alu    = 1'b1;
                issue_pkg::CTRL_FLOW: exp_valid.branch = 1'b1;
                issue_pkg::MULT:      exp_valid.mult   = 1'b1;
                issue_pkg::LOAD:      exp_valid.lsu    = 1'b1;
                issue_pkg::STORE:     exp_valid.lsu    = 1'b1;
                issue_pkg::CSR:       exp_valid.csr    = 1'b1;
                default:              exp_valid        = '0;
            endcase
        end
        // commits land at the same edge, higher port last
        for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
            if (commit[p].we && (commit[p].waddr != 0)) begin
                model_regs[commit[p].waddr] = commit[p].wdata;
            end
        end
    endtask

//--- testbench/tb_issue_read_operands.sv
module tb_issue_read_operands;

    localparam int unsigned TEST_CYCLES = 400;
    localparam int unsigned NR_TESTS    = 6;

    logic                             clk_i;
    logic                             rst_ni;
    logic                             flush;
    issue_pkg::issue_entry_t          issue_instr;
    logic                             issue_valid;
    logic                             issue_ready;
    logic [issue_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [issue_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [issue_pkg::XLEN-1:0]       rs1_val;
    logic                             rs1_valid;
    logic [issue_pkg::XLEN-1:0]       rs2_val;
    logic                             rs2_valid;
    issue_pkg::clobber_t              clobber;
    issue_pkg::fu_ready_t             fu_ready;
    issue_pkg::commit_vec_t           commit;
    issue_pkg::fu_data_t              fu_data;
    issue_pkg::fu_valid_t             fu_valid;

    int unsigned test_errs;
    int unsigned total_errs;
    int unsigned checks;
    int unsigned failed_tests;

    `include "tb_issue_model.svh"

    issue_read_operands i_issue_read_operands (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .flush_i       ( flush       ),
        .issue_instr_i ( issue_instr ),
        .issue_valid_i ( issue_valid ),
        .issue_ready_o ( issue_ready ),
        .rs1_o         ( rs1_addr    ),
        .rs2_o         ( rs2_addr    ),
        .rs1_i         ( rs1_val     ),
        .rs1_valid_i   ( rs1_valid   ),
        .rs2_i         ( rs2_val     ),
        .rs2_valid_i   ( rs2_valid   ),
        .clobber_i     ( clobber     ),
        .fu_ready_i    ( fu_ready    ),
        .commit_i      ( commit      ),
        .fu_data_o     ( fu_data     ),
        .fu_valid_o    ( fu_valid    )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    function automatic logic chance(input int unsigned pct);
        return ($urandom % 100) < pct;
    endfunction

    function automatic issue_pkg::issue_entry_t random_entry(input int unsigned flag_pct);
        issue_pkg::issue_entry_t e;
        e.pc       = $urandom;
        e.trans_id = 3'($urandom);
        e.fu       = issue_pkg::fu_e'($urandom % 7);
        e.op       = chance(15) ? issue_pkg::SFENCE_VMA : issue_pkg::fu_op_e'($urandom % 13);
        // x0 shows up more often than by chance
        e.rs1      = chance(10) ? 5'd0 : 5'($urandom);
        e.rs2      = chance(10) ? 5'd0 : 5'($urandom);
        e.rd       = 5'($urandom);
        e.result   = $urandom;
        e.use_imm  = chance(flag_pct);
        e.use_pc   = chance(flag_pct);
        e.use_zimm = chance(flag_pct / 2);
        e.ex_valid = chance(8);
        return e;
    endfunction

    task automatic idle_inputs();
        flush       = 1'b0;
        issue_instr = '0;
        issue_valid = 1'b0;
        rs1_val     = '0;
        rs1_valid   = 1'b0;
        rs2_val     = '0;
        rs2_valid   = 1'b0;
        fu_ready    = '0;
        commit      = '0;
        for (int unsigned r = 0; r < issue_pkg::NR_REGS; r++) begin
            clobber[r] = issue_pkg::NONE;
        end
    endtask

    // a stalled entry is held, everything else changes freely
    task automatic drive_inputs(input logic hold, input int unsigned none_pct,
                                input int unsigned flag_pct, input int unsigned ready_pct,
                                input int unsigned flush_pct);
        if (!hold) begin
            issue_valid = chance(85);
            issue_instr = random_entry(flag_pct);
        end
        for (int unsigned r = 0; r < issue_pkg::NR_REGS; r++) begin
            clobber[r] = chance(none_pct) ? issue_pkg::NONE : issue_pkg::fu_e'(1 + $urandom % 6);
        end
        rs1_val      = $urandom;
        rs1_valid    = chance(60);
        rs2_val      = $urandom;
        rs2_valid    = chance(60);
        fu_ready.flu = chance(ready_pct);
        fu_ready.lsu = chance(ready_pct);
        flush        = chance(flush_pct);
        for (int unsigned p = 0; p < issue_pkg::NR_COMMIT_PORTS; p++) begin
            commit[p].we    = chance(50);
            commit[p].waddr = 5'($urandom);
            commit[p].wdata = $urandom;
        end
        // retire rd now and then, frees a WAW stall
        if (chance(25)) begin
            commit[0].waddr = issue_instr.rd;
        end
        // both ports on one register carry the same value
        if (commit[1].waddr == commit[0].waddr) begin
            commit[1].wdata = commit[0].wdata;
        end
    endtask

    // ----------------------------------------
    // checking and reporting
    // ----------------------------------------
    task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] got);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, exp, got);
            test_errs++;
        end
    endtask

    task automatic report_test(input string name);
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s %0d mismatches", name, test_errs);
            failed_tests++;
        end
    endtask

    task automatic check_reset();
        test_errs = 0;
        compare("fu_valid_o", exp_valid, fu_valid);
        compare("fu_data_o", exp_data, fu_data);
        compare("issue_ready_o", 1'b0, issue_ready);
        report_test("reset");
    endtask

    // drive 2 after the edge, ready at 3, registered outputs at 1 after the next edge
    task automatic run_test(input string name, input int unsigned none_pct,
                            input int unsigned flag_pct, input int unsigned ready_pct,
                            input int unsigned flush_pct);
        logic hold;
        logic exp_ready;
        test_errs = 0;
        hold      = 1'b0;
        for (int unsigned c = 0; c < TEST_CYCLES; c++) begin
            drive_inputs(hold, none_pct, flag_pct, ready_pct, flush_pct);
            #1;
            exp_ready = model_ready();
            compare("issue_ready_o", exp_ready, issue_ready);
            // scoreboard lookup addresses follow the offered entry
            compare("rs1_o", issue_instr.rs1, rs1_addr);
            compare("rs2_o", issue_instr.rs2, rs2_addr);
            hold = issue_valid && !issue_ready;
            model_step(exp_ready);
            @(posedge clk_i);
            #1;
            compare("fu_valid_o", exp_valid, fu_valid);
            compare("fu_data_o", exp_data, fu_data);
            #1;
        end
        report_test(name);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(53));
        total_errs   = 0;
        checks       = 0;
        failed_tests = 0;
        rst_ni       = 1'b0;
        idle_inputs();
        model_reset();
        repeat (5) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        check_reset();
        run_test("regfile_reads", 100, 0, 100, 0);
        run_test("forwarding", 30, 10, 100, 0);
        run_test("issue_gating", 60, 20, 50, 0);
        run_test("operand_select", 70, 50, 80, 5);
        run_test("flush", 70, 20, 80, 40);
        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 NR_TESTS, failed_tests, checks, total_errs);
        if (total_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // all tests plus reset and some slack
    initial begin
        #((5 * TEST_CYCLES + 10) * 20 + 1000);
        $display("watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+testbench
hdl/issue_pkg.sv
hdl/int_regfile.sv
hdl/operand_hazard.sv
hdl/issue_gate.sv
hdl/issue_ex_regs.sv
hdl/issue_read_operands.sv
testbench/tb_issue_read_operands.sv
